//--- verilog/prf_defines.svh
// sizing macros for the banked physical register file
`ifndef PRF_DEFINES_SVH
`define PRF_DEFINES_SVH

// register file geometry
`define PRF_PR_COUNT 32
`define PRF_BANK_COUNT 4
`define PRF_LOG_PR_COUNT 5
`define PRF_LOG_BANK_COUNT 2

// requesters served by the arbiter
`define PRF_RR_COUNT 4
`define PRF_WR_COUNT 3

// payload widths
`define PRF_LOG_ROB_ENTRIES 6
`define PRF_DATA_WIDTH 32

`endif

//--- verilog/prf_pkg.sv
// shared types for the banked physical register file
`include "prf_defines.svh"

package prf_pkg;

    // row within a bank, the upper bits of the register number
    typedef logic [`PRF_LOG_PR_COUNT-`PRF_LOG_BANK_COUNT-1:0] upper_pr_t;

    // bank select, the low bits of the register number
    typedef logic [`PRF_LOG_BANK_COUNT-1:0] bank_t;

    typedef struct packed {
        upper_pr_t upper;
        bank_t     bank;
    } pr_fields_t;

    // physical register number, flat or split into row and bank
    typedef union packed {
        logic [`PRF_LOG_PR_COUNT-1:0] index;
        pr_fields_t                   fields;
    } pr_t;

    typedef logic [`PRF_LOG_ROB_ENTRIES-1:0] rob_index_t;

    typedef logic [`PRF_DATA_WIDTH-1:0] data_t;

endpackage

//--- verilog/prf_bank_if.sv
// read and write commands from the PRF arbiter to one bank
`timescale 1ns/1ns

interface prf_bank_if;
    import prf_pkg::*;

    // two read ports
    logic [1:0]      rd_en;
    upper_pr_t [1:0] rd_upper;

    // one write port, rob index rides along for the complete bus
    logic       wr_en;
    upper_pr_t  wr_upper;
    data_t      wr_data;
    rob_index_t wr_rob_index;

    modport arbiter (
        output rd_en,
        output rd_upper,
        output wr_en,
        output wr_upper,
        output wr_data,
        output wr_rob_index
    );

    modport bank (
        input rd_en,
        input rd_upper,
        input wr_en,
        input wr_upper,
        input wr_data
    );

    // broadcast stage only sees the write side
    modport bus (
        input wr_en,
        input wr_upper,
        input wr_data,
        input wr_rob_index
    );

endinterface

//--- verilog/prf_arbiter.sv
// fixed priority arbiter granting read ports and write slots per PRF bank
`timescale 1ns/1ns
`include "prf_defines.svh"

module prf_arbiter (
    input logic CLK,
    input logic rst_n,

    // read requests
    input logic [`PRF_RR_COUNT-1:0]          read_req_valid_by_rr,
    input prf_pkg::pr_t [`PRF_RR_COUNT-1:0]  read_req_pr_by_rr,

    // read responses, one cycle later
    output logic [`PRF_RR_COUNT-1:0] read_resp_ack_by_rr,
    output logic [`PRF_RR_COUNT-1:0] read_resp_port_by_rr,

    // write requests
    input logic [`PRF_WR_COUNT-1:0]                wb_valid_by_wr,
    input prf_pkg::data_t [`PRF_WR_COUNT-1:0]      wb_data_by_wr,
    input prf_pkg::pr_t [`PRF_WR_COUNT-1:0]        wb_pr_by_wr,
    input prf_pkg::rob_index_t [`PRF_WR_COUNT-1:0] wb_rob_index_by_wr,

    output logic [`PRF_WR_COUNT-1:0] wb_ready_by_wr,

    // bank commands
    prf_bank_if.arbiter bank [`PRF_BANK_COUNT]
);
    import prf_pkg::*;

    // bank decode per requester
    bank_t [`PRF_RR_COUNT-1:0] rd_bank_by_rr;
    bank_t [`PRF_WR_COUNT-1:0] wr_bank_by_wr;

    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] rd_mask_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] wr_mask_by_bank;

    // read grant state
    logic [`PRF_BANK_COUNT-1:0][1:0]      rd_count_by_bank;
    logic [`PRF_RR_COUNT-1:0]             rd_grant_by_rr;
    logic [`PRF_RR_COUNT-1:0]             rd_port_by_rr;
    logic [`PRF_BANK_COUNT-1:0][1:0]      rd_en_by_bank;
    upper_pr_t [`PRF_BANK_COUNT-1:0][1:0] rd_upper_by_bank;

    // write grant state
    logic [`PRF_BANK_COUNT-1:0]       wr_en_by_bank;
    upper_pr_t [`PRF_BANK_COUNT-1:0]  wr_upper_by_bank;
    data_t [`PRF_BANK_COUNT-1:0]      wr_data_by_bank;
    rob_index_t [`PRF_BANK_COUNT-1:0] wr_rob_index_by_bank;

    // --------------------
    // request decode

    always_comb begin
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            rd_bank_by_rr[r] = read_req_pr_by_rr[r].fields.bank;
        end
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            wr_bank_by_wr[w] = wb_pr_by_wr[w].fields.bank;
        end
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                rd_mask_by_bank[b][r] = read_req_valid_by_rr[r] && (rd_bank_by_rr[r] == b);
            end
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                wr_mask_by_bank[b][w] = wb_valid_by_wr[w] && (wr_bank_by_wr[w] == b);
            end
        end
    end

    // --------------------
    // read arbitration

    // lowest requester first, two ports per bank
    always_comb begin
        rd_count_by_bank = '0;
        rd_grant_by_rr = '0;
        rd_port_by_rr = '0;
        rd_en_by_bank = '0;
        rd_upper_by_bank = '0;
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            if (rd_mask_by_bank[rd_bank_by_rr[r]][r]
                    && rd_count_by_bank[rd_bank_by_rr[r]] != 2'd2) begin
                rd_grant_by_rr[r] = 1'b1;
                rd_port_by_rr[r] = rd_count_by_bank[rd_bank_by_rr[r]][0];
                rd_en_by_bank[rd_bank_by_rr[r]][rd_port_by_rr[r]] = 1'b1;
                rd_upper_by_bank[rd_bank_by_rr[r]][rd_port_by_rr[r]] =
                    read_req_pr_by_rr[r].fields.upper;
                rd_count_by_bank[rd_bank_by_rr[r]] = rd_count_by_bank[rd_bank_by_rr[r]] + 2'd1;
            end
        end
    end

    // ack lines up with the bank's registered read data
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            read_resp_ack_by_rr <= '0;
            read_resp_port_by_rr <= '0;
        end else begin
            read_resp_ack_by_rr <= rd_grant_by_rr;
            read_resp_port_by_rr <= rd_port_by_rr;
        end
    end

    // --------------------
    // write arbitration

    // one writer per bank, the rest hold
    always_comb begin
        wb_ready_by_wr = '0;
        wr_en_by_bank = '0;
        wr_upper_by_bank = '0;
        wr_data_by_bank = '0;
        wr_rob_index_by_bank = '0;
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            if (wr_mask_by_bank[wr_bank_by_wr[w]][w] && !wr_en_by_bank[wr_bank_by_wr[w]]) begin
                wb_ready_by_wr[w] = 1'b1;
                wr_en_by_bank[wr_bank_by_wr[w]] = 1'b1;
                wr_upper_by_bank[wr_bank_by_wr[w]] = wb_pr_by_wr[w].fields.upper;
                wr_data_by_bank[wr_bank_by_wr[w]] = wb_data_by_wr[w];
                wr_rob_index_by_bank[wr_bank_by_wr[w]] = wb_rob_index_by_wr[w];
            end
        end
    end

    // --------------------
    // bank command drive

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : gen_bank_cmd
        assign bank[b].rd_en = rd_en_by_bank[b];
        assign bank[b].rd_upper = rd_upper_by_bank[b];
        assign bank[b].wr_en = wr_en_by_bank[b];
        assign bank[b].wr_upper = wr_upper_by_bank[b];
        assign bank[b].wr_data = wr_data_by_bank[b];
        assign bank[b].wr_rob_index = wr_rob_index_by_bank[b];

        // acks in N+1 for requests made to this bank in N
        assert property (@(posedge CLK) disable iff (!rst_n)
            $countones(read_resp_ack_by_rr & $past(rd_mask_by_bank[b])) <= 2);

        // handshake seen by the writers, not the grant vector
        assert property (@(posedge CLK) disable iff (!rst_n)
            $onehot0(wb_valid_by_wr & wb_ready_by_wr & wr_mask_by_bank[b]));
    end

endmodule

//--- verilog/prf_bank.sv
// one PRF bank with two registered read ports and one write port
`timescale 1ns/1ns
`include "prf_defines.svh"

module prf_bank (
    input logic CLK,
    input logic rst_n,

    prf_bank_if.bank port,

    output prf_pkg::data_t [1:0] rd_data_by_port
);
    import prf_pkg::*;

    // row storage, indexed by the upper register bits
    data_t [`PRF_PR_COUNT/`PRF_BANK_COUNT-1:0] rows;

    // write lands at the acceptance edge
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            rows <= '0;
        end else if (port.wr_en) begin
            rows[port.wr_upper] <= port.wr_data;
        end
    end

    // reads see the row before a same-cycle write
    always_ff @(posedge CLK) begin
        for (int p = 0; p < 2; p++) begin
            if (port.rd_en[p]) begin
                rd_data_by_port[p] <= rows[port.rd_upper[p]];
            end
        end
    end

    // arbiter must hand over a clean row on every write
    assert property (@(posedge CLK) disable iff (!rst_n)
        port.wr_en |-> !$isunknown(port.wr_upper));

endmodule

//--- verilog/prf_wb_bus.sv
// writeback, forward and complete broadcasts for one PRF bank
`timescale 1ns/1ns

module prf_wb_bus (
    input logic CLK,
    input logic rst_n,

    prf_bank_if.bus port,

    // writeback bus
    output logic                wb_bus_valid,
    output prf_pkg::upper_pr_t  wb_bus_upper_pr,

    // forward data bus
    output prf_pkg::data_t      forward_data,

    // complete bus
    output logic                complete_valid,
    output prf_pkg::rob_index_t complete_rob_index
);

    logic wr_valid_q;

    // one pulse per accepted write, back to back allowed
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= port.wr_en;
        end
    end

    // payload only moves on a write
    always_ff @(posedge CLK) begin
        if (port.wr_en) begin
            wb_bus_upper_pr <= port.wr_upper;
            forward_data <= port.wr_data;
            complete_rob_index <= port.wr_rob_index;
        end
    end

    // writeback and complete fire together
    assign wb_bus_valid = wr_valid_q;
    assign complete_valid = wr_valid_q;

endmodule

//--- verilog/prf.sv
// banked physical register file with arbitration and writeback broadcasts
`timescale 1ns/1ns
`include "prf_defines.svh"

module prf (
    input logic CLK,
    input logic rst_n,

    // read requests by requester
    input logic [`PRF_RR_COUNT-1:0]                         read_req_valid_by_rr,
    input logic [`PRF_RR_COUNT-1:0][`PRF_LOG_PR_COUNT-1:0]  read_req_pr_by_rr,

    // read responses by requester
    output logic [`PRF_RR_COUNT-1:0] read_resp_ack_by_rr,
    output logic [`PRF_RR_COUNT-1:0] read_resp_port_by_rr,

    // read data by bank and port
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0][1:0] read_data_by_bank_by_port,

    // writes by requester
    input logic [`PRF_WR_COUNT-1:0]                         wb_valid_by_wr,
    input prf_pkg::data_t [`PRF_WR_COUNT-1:0]               wb_data_by_wr,
    input logic [`PRF_WR_COUNT-1:0][`PRF_LOG_PR_COUNT-1:0]  wb_pr_by_wr,
    input prf_pkg::rob_index_t [`PRF_WR_COUNT-1:0]          wb_rob_index_by_wr,

    output logic [`PRF_WR_COUNT-1:0] wb_ready_by_wr,

    // writeback bus by bank
    output logic [`PRF_BANK_COUNT-1:0]               wb_bus_valid_by_bank,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0] wb_bus_upper_pr_by_bank,

    // forward data by bank
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0] forward_data_bus_by_bank,

    // complete bus by bank
    output logic [`PRF_BANK_COUNT-1:0]                complete_bus_valid_by_bank,
    output prf_pkg::rob_index_t [`PRF_BANK_COUNT-1:0] complete_bus_rob_index_by_bank
);

    prf_bank_if bank_if [`PRF_BANK_COUNT] ();

    // --------------------
    // arbitration

    prf_arbiter arbiter_i (
        .CLK(CLK),
        .rst_n(rst_n),
        .read_req_valid_by_rr(read_req_valid_by_rr),
        .read_req_pr_by_rr(read_req_pr_by_rr),
        .read_resp_ack_by_rr(read_resp_ack_by_rr),
        .read_resp_port_by_rr(read_resp_port_by_rr),
        .wb_valid_by_wr(wb_valid_by_wr),
        .wb_data_by_wr(wb_data_by_wr),
        .wb_pr_by_wr(wb_pr_by_wr),
        .wb_rob_index_by_wr(wb_rob_index_by_wr),
        .wb_ready_by_wr(wb_ready_by_wr),
        .bank(bank_if)
    );

    // --------------------
    // banks and broadcasts

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : gen_bank
        prf_bank bank_i (
            .CLK(CLK),
            .rst_n(rst_n),
            .port(bank_if[b]),
            .rd_data_by_port(read_data_by_bank_by_port[b])
        );

        prf_wb_bus wb_bus_i (
            .CLK(CLK),
            .rst_n(rst_n),
            .port(bank_if[b]),
            .wb_bus_valid(wb_bus_valid_by_bank[b]),
            .wb_bus_upper_pr(wb_bus_upper_pr_by_bank[b]),
            .forward_data(forward_data_bus_by_bank[b]),
            .complete_valid(complete_bus_valid_by_bank[b]),
            .complete_rob_index(complete_bus_rob_index_by_bank[b])
        );
    end

endmodule

//--- verification/prf_tb.sv
// table-driven testbench for the banked PRF against a reference model
`timescale 1ns/1ns
`include "prf_defines.svh"

module prf_tb;

    localparam int row_count = 40;
    localparam int directed_count = 10;
    localparam int upper_lsb = `PRF_LOG_BANK_COUNT;

    logic CLK;
    logic rst_n;
    logic [`PRF_RR_COUNT-1:0] read_req_valid_by_rr;
    logic [`PRF_RR_COUNT-1:0][`PRF_LOG_PR_COUNT-1:0] read_req_pr_by_rr;
    logic [`PRF_RR_COUNT-1:0] read_resp_ack_by_rr;
    logic [`PRF_RR_COUNT-1:0] read_resp_port_by_rr;
    logic [`PRF_BANK_COUNT-1:0][1:0][`PRF_DATA_WIDTH-1:0] read_data_by_bank_by_port;
    logic [`PRF_WR_COUNT-1:0] wb_valid_by_wr;
    logic [`PRF_WR_COUNT-1:0][`PRF_DATA_WIDTH-1:0] wb_data_by_wr;
    logic [`PRF_WR_COUNT-1:0][`PRF_LOG_PR_COUNT-1:0] wb_pr_by_wr;
    logic [`PRF_WR_COUNT-1:0][`PRF_LOG_ROB_ENTRIES-1:0] wb_rob_index_by_wr;
    logic [`PRF_WR_COUNT-1:0] wb_ready_by_wr;
    logic [`PRF_BANK_COUNT-1:0] wb_bus_valid_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_LOG_PR_COUNT-upper_lsb-1:0] wb_bus_upper_pr_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] forward_data_bus_by_bank;
    logic [`PRF_BANK_COUNT-1:0] complete_bus_valid_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_LOG_ROB_ENTRIES-1:0] complete_bus_rob_index_by_bank;

    // --------------------
    // stimulus and expected values per row

    logic [`PRF_RR_COUNT-1:0] row_rd_valid [row_count];
    logic [`PRF_RR_COUNT-1:0][`PRF_LOG_PR_COUNT-1:0] row_rd_pr [row_count];
    logic [`PRF_WR_COUNT-1:0] row_wr_valid [row_count];
    logic [`PRF_WR_COUNT-1:0][`PRF_LOG_PR_COUNT-1:0] row_wr_pr [row_count];
    logic [`PRF_WR_COUNT-1:0][`PRF_DATA_WIDTH-1:0] row_wr_data [row_count];
    logic [`PRF_WR_COUNT-1:0][`PRF_LOG_ROB_ENTRIES-1:0] row_wr_rob [row_count];

    logic [`PRF_WR_COUNT-1:0] exp_ready [row_count];
    logic [`PRF_RR_COUNT-1:0] exp_ack [row_count];
    logic [`PRF_RR_COUNT-1:0] exp_port [row_count];
    logic [`PRF_RR_COUNT-1:0][`PRF_DATA_WIDTH-1:0] exp_rd_data [row_count];
    logic [`PRF_BANK_COUNT-1:0] exp_bus_valid [row_count];
    logic [`PRF_BANK_COUNT-1:0][`PRF_LOG_PR_COUNT-upper_lsb-1:0] exp_bus_upper [row_count];
    logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] exp_bus_data [row_count];
    logic [`PRF_BANK_COUNT-1:0][`PRF_LOG_ROB_ENTRIES-1:0] exp_bus_rob [row_count];

    integer seed = 12;
    int errors = 0;

    prf dut_i (.*);

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // --------------------
    // helpers

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic set_read(input int i, input int r, input logic [4:0] pr);
        row_rd_valid[i][r] = 1'b1;
        row_rd_pr[i][r] = pr;
    endtask

    task automatic set_write(input int i, input int w, input logic [4:0] pr,
                             input logic [31:0] data, input logic [5:0] rob);
        row_wr_valid[i][w] = 1'b1;
        row_wr_pr[i][w] = pr;
        row_wr_data[i][w] = data;
        row_wr_rob[i][w] = rob;
    endtask

    // reference model over the rows in order
    // refused writers repeat their request in the next row
    task automatic build_expected();
        logic [`PRF_DATA_WIDTH-1:0] regs [`PRF_PR_COUNT];
        int rd_count [`PRF_BANK_COUNT];
        logic [`PRF_BANK_COUNT-1:0] taken;
        logic [`PRF_LOG_PR_COUNT-1:0] pr;
        int b;
        for (int k = 0; k < `PRF_PR_COUNT; k++) regs[k] = '0;
        for (int i = 0; i < row_count; i++) begin
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                if (i > 0 && row_wr_valid[i-1][w] && !exp_ready[i-1][w]) begin
                    set_write(i, w, row_wr_pr[i-1][w], row_wr_data[i-1][w], row_wr_rob[i-1][w]);
                end
            end
            taken = '0;
            exp_ready[i] = '0;
            exp_bus_valid[i] = '0;
            exp_bus_upper[i] = '0;
            exp_bus_data[i] = '0;
            exp_bus_rob[i] = '0;
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                pr = row_wr_pr[i][w];
                b = pr[upper_lsb-1:0];
                if (row_wr_valid[i][w] && !taken[b]) begin
                    taken[b] = 1'b1;
                    exp_ready[i][w] = 1'b1;
                    exp_bus_valid[i][b] = 1'b1;
                    exp_bus_upper[i][b] = pr[`PRF_LOG_PR_COUNT-1:upper_lsb];
                    exp_bus_data[i][b] = row_wr_data[i][w];
                    exp_bus_rob[i][b] = row_wr_rob[i][w];
                end
            end
            for (int k = 0; k < `PRF_BANK_COUNT; k++) rd_count[k] = 0;
            exp_ack[i] = '0;
            exp_port[i] = '0;
            exp_rd_data[i] = '0;
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                pr = row_rd_pr[i][r];
                b = pr[upper_lsb-1:0];
                if (row_rd_valid[i][r] && rd_count[b] < 2) begin
                    exp_ack[i][r] = 1'b1;
                    // second winner in a bank gets port 1
                    exp_port[i][r] = (rd_count[b] == 1);
                    // same-cycle writes are not yet visible
                    exp_rd_data[i][r] = regs[pr];
                    rd_count[b]++;
                end
            end
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                if (exp_ready[i][w]) regs[row_wr_pr[i][w]] = row_wr_data[i][w];
            end
        end
    endtask

    // outputs one cycle after row i
    task automatic check_delayed(input int i);
        logic [`PRF_LOG_PR_COUNT-1:0] pr;
        check_value("read_resp_ack_by_rr", exp_ack[i], read_resp_ack_by_rr);
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            if (exp_ack[i][r]) begin
                pr = row_rd_pr[i][r];
                check_value($sformatf("read_resp_port_by_rr[%0d]", r),
                            exp_port[i][r], read_resp_port_by_rr[r]);
                check_value($sformatf("read_data_by_bank_by_port[%0d][%0d]",
                                      pr[upper_lsb-1:0], exp_port[i][r]), exp_rd_data[i][r],
                            read_data_by_bank_by_port[pr[upper_lsb-1:0]][exp_port[i][r]]);
            end
        end
        check_value("wb_bus_valid_by_bank", exp_bus_valid[i], wb_bus_valid_by_bank);
        check_value("complete_bus_valid_by_bank", exp_bus_valid[i], complete_bus_valid_by_bank);
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            if (exp_bus_valid[i][b]) begin
                check_value($sformatf("wb_bus_upper_pr_by_bank[%0d]", b),
                            exp_bus_upper[i][b], wb_bus_upper_pr_by_bank[b]);
                check_value($sformatf("forward_data_bus_by_bank[%0d]", b),
                            exp_bus_data[i][b], forward_data_bus_by_bank[b]);
                check_value($sformatf("complete_bus_rob_index_by_bank[%0d]", b),
                            exp_bus_rob[i][b], complete_bus_rob_index_by_bank[b]);
            end
        end
    endtask

    // --------------------
    // watchdog

    initial begin
        #((row_count + 20) * 10);
        $display("watchdog expired, the table did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------
    // main sequence

    initial begin
        rst_n = 1'b0;
        read_req_valid_by_rr = '0;
        read_req_pr_by_rr = '0;
        wb_valid_by_wr = '0;
        wb_data_by_wr = '0;
        wb_pr_by_wr = '0;
        wb_rob_index_by_wr = '0;

        for (int i = 0; i < row_count; i++) begin
            row_rd_valid[i] = '0;
            row_rd_pr[i] = '0;
            row_wr_valid[i] = '0;
            row_wr_pr[i] = '0;
            row_wr_data[i] = '0;
            row_wr_rob[i] = '0;
        end
        // reads of reset values across all banks
        set_read(1, 0, 5'd5);
        set_read(1, 1, 5'd10);
        set_read(1, 2, 5'd15);
        set_read(1, 3, 5'd0);
        // writers to different banks
        set_write(2, 0, 5'd6, 32'h1111_aaaa, 6'd1);
        set_write(2, 1, 5'd9, 32'h2222_bbbb, 6'd2);
        set_write(2, 2, 5'd19, 32'h3333_cccc, 6'd3);
        set_read(3, 0, 5'd6);
        set_read(3, 1, 5'd19);
        // read and write of the same register
        set_write(4, 0, 5'd6, 32'h4444_dddd, 6'd4);
        set_read(4, 0, 5'd6);
        set_read(5, 0, 5'd6);
        // three readers on bank 1
        set_read(6, 0, 5'd1);
        set_read(6, 1, 5'd9);
        set_read(6, 2, 5'd5);
        set_read(6, 3, 5'd2);
        // two writers on bank 0 and the second holds into row 8
        set_write(7, 0, 5'd4, 32'h5555_eeee, 6'd5);
        set_write(7, 1, 5'd8, 32'h6666_ffff, 6'd6);
        set_write(7, 2, 5'd31, 32'h7777_0000, 6'd7);
        set_read(8, 0, 5'd4);
        set_read(8, 1, 5'd31);

        // random rows on 16 registers for more collisions
        for (int i = directed_count; i < row_count; i++) begin
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                if ($random(seed) & 1) set_read(i, r, $random(seed) & 5'h0f);
            end
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                if ($random(seed) & 1) begin
                    set_write(i, w, $random(seed) & 5'h0f, $random(seed), $random(seed));
                end
            end
        end
        build_expected();

        repeat (4) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        check_value("read_resp_ack_by_rr", '0, read_resp_ack_by_rr);
        check_value("wb_bus_valid_by_bank", '0, wb_bus_valid_by_bank);
        check_value("complete_bus_valid_by_bank", '0, complete_bus_valid_by_bank);

        for (int i = 0; i <= row_count; i++) begin
            @(posedge CLK);
            if (i < row_count) begin
                read_req_valid_by_rr <= row_rd_valid[i];
                read_req_pr_by_rr <= row_rd_pr[i];
                wb_valid_by_wr <= row_wr_valid[i];
                wb_data_by_wr <= row_wr_data[i];
                wb_pr_by_wr <= row_wr_pr[i];
                wb_rob_index_by_wr <= row_wr_rob[i];
            end else begin
                read_req_valid_by_rr <= '0;
                wb_valid_by_wr <= '0;
            end
            @(negedge CLK);
            if (i < row_count) check_value("wb_ready_by_wr", exp_ready[i], wb_ready_by_wr);
            if (i > 0) check_delayed(i - 1);
        end

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/prf_pkg.sv
verilog/prf_bank_if.sv
verilog/prf_arbiter.sv
verilog/prf_bank.sv
verilog/prf_wb_bus.sv
verilog/prf.sv
verification/prf_tb.sv

//--- Bender.yml
package:
  name: prf

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/prf_pkg.sv
      - verilog/prf_bank_if.sv
      - verilog/prf_arbiter.sv
      - verilog/prf_bank.sv
      - verilog/prf_wb_bus.sv
      - verilog/prf.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/prf_tb.sv
